//--- all.f
design/watch_pkg.sv
design/panel_input.sv
design/time_keeper.sv
design/alarm_unit.sv
design/melody_recorder.sv
design/tone_generator.sv
design/watch_top.sv
sim/watch_tb.sv

//--- sim/watch_tb.sv
`timescale 1ns/1ps

module watch_tb;
    typedef struct packed {
        logic [watch_pkg::MODE_W-1:0] mode;
        logic [3:0] key;
        logic [3:0] count;
        logic [watch_pkg::HOUR_W-1:0] hour;
        logic [watch_pkg::MIN_W-1:0] minute;
    } entry_t;

    logic clock;
    logic reset;
    logic [watch_pkg::MODE_IN_W-1:0] mode;
    watch_pkg::button_word_u button;
    logic [watch_pkg::HOUR_W-1:0] hour;
    logic [watch_pkg::MIN_W-1:0] minute;
    logic [watch_pkg::MIN_W-1:0] second;
    logic [watch_pkg::LED_W-1:0] led;
    logic piezo;

    logic [31:0] lfsr_state;
    entry_t set_table [5];
    int tone_periods [watch_pkg::NOTE_W];
    int hour_off;
    int minute_off;
    int extra;
    int note_idx;
    int recorded_half;
    entry_t entry;

    watch_top dut0 (
        .clock(clock),
        .reset(reset),
        .mode(mode),
        .button(button.keys),
        .hour(hour),
        .minute(minute),
        .second(second),
        .led(led),
        .piezo(piezo)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    function automatic entry_t make_entry(input int key, input int count, input int h,
                                          input int m);
        entry_t e;
        e.mode = watch_pkg::MODE_SET_TIME;
        e.key = key;
        e.count = count;
        e.hour = h;
        e.minute = m;
        return e;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_time(input logic [watch_pkg::HOUR_W-1:0] exp_hour,
                              input logic [watch_pkg::MIN_W-1:0] exp_minute,
                              input logic [watch_pkg::MIN_W-1:0] exp_second);
        if (hour !== exp_hour || minute !== exp_minute || second !== exp_second)
            report_mismatch($sformatf("time %0d:%0d:%0d, expected %0d:%0d:%0d",
                hour, minute, second, exp_hour, exp_minute, exp_second));
    endtask

    task automatic check_led(input logic [watch_pkg::LED_W-1:0] exp_led);
        if (led !== exp_led)
            report_mismatch($sformatf("led %b, expected %b", led, exp_led));
    endtask

    task automatic check_half_period(input int expected, input int measured);
        if (measured != expected)
            report_mismatch($sformatf("piezo edge gap %0d cycles, expected %0d",
                measured, expected));
    endtask

    task automatic select_mode(input logic [watch_pkg::MODE_W-1:0] code);
        @(negedge clock);
        case (code)  // Highest raw mode bit wins in the DUT
            watch_pkg::MODE_SET_TIME: mode = 4'b1000;
            watch_pkg::MODE_SET_ALARM: mode = 4'b0100;
            watch_pkg::MODE_RECORD: mode = 4'b0010;
            default: mode = 4'b0000;
        endcase
    endtask

    task automatic press_key(input int key);
        @(negedge clock);
        button.keys[key] = 1'b1;
        repeat (3 * watch_pkg::CLOCKS_PER_TICK) @(negedge clock);
        button.keys[key] = 1'b0;
        repeat (3 * watch_pkg::CLOCKS_PER_TICK) @(negedge clock);
    endtask

    task automatic press_times(input int key, input int count);
        repeat (count) press_key(key);
    endtask

    // Shortest way round the dial to the target value
    task automatic set_field(input int down_key, input int up_key, input int cur,
                             input int target, input int limit);
        int up_n;
        up_n = (target - cur + limit) % limit;
        if (up_n <= limit / 2) press_times(up_key, up_n);
        else press_times(down_key, limit - up_n);
    endtask

    task automatic wait_second_change(input int limit);
        logic [watch_pkg::MIN_W-1:0] start_second;
        int waited;
        start_second = second;
        waited = 0;
        while (second === start_second && waited < limit) begin
            @(negedge clock);
            waited++;
        end
        if (second === start_second) report_problem("Timeout waiting for the seconds to advance");
    endtask

    task automatic wait_minute_change(input int limit);
        logic [watch_pkg::MIN_W-1:0] start_minute;
        int waited;
        start_minute = minute;
        waited = 0;
        while (minute === start_minute && waited < limit) begin
            @(negedge clock);
            waited++;
        end
        if (minute === start_minute) report_problem("Timeout waiting for the minutes to advance");
    endtask

    task automatic wait_first_edge(input int limit);
        logic start_level;
        int waited;
        start_level = piezo;
        waited = 0;
        while (piezo === start_level && waited < limit) begin
            @(negedge clock);
            waited++;
        end
        if (piezo === start_level) report_problem("Timeout waiting for the alarm melody to start");
    endtask

    task automatic wait_quiet(input int limit);
        int quiet;
        int waited;
        quiet = 0;
        waited = 0;
        while (quiet < 4000 && waited < limit) begin
            @(negedge clock);
            waited++;
            quiet = piezo ? 0 : quiet + 1;  // Longer than any half period
        end
        if (quiet < 4000) report_problem("Piezo kept sounding after the melody should have ended");
    endtask

    // First edge has no known start, so its gap is skipped
    task automatic measure_tone(input int exp_half, input int span);
        logic last;
        int since;
        int edges;
        last = piezo;
        since = 0;
        edges = 0;
        repeat (span) begin
            @(negedge clock);
            since++;
            if (piezo !== last) begin
                if (edges > 0) check_half_period(exp_half, since);
                edges++;
                since = 0;
                last = piezo;
            end else if (edges > 0 && since > exp_half) begin
                check_half_period(exp_half, since);  // Tone stopped early
            end
        end
        if (edges < 3) report_problem("No tone seen on the piezo output");
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        mode = '0;
        button = '0;
        lfsr_state = 32'h3574_1231;
        hour_off = 0;
        minute_off = 0;
        tone_periods[0] = watch_pkg::TONE_PERIOD_C2;
        tone_periods[1] = watch_pkg::TONE_PERIOD_D2;
        tone_periods[2] = watch_pkg::TONE_PERIOD_E2;
        tone_periods[3] = watch_pkg::TONE_PERIOD_F2;
        tone_periods[4] = watch_pkg::TONE_PERIOD_G2;
        tone_periods[5] = watch_pkg::TONE_PERIOD_A2;
        tone_periods[6] = watch_pkg::TONE_PERIOD_B2;
        tone_periods[7] = watch_pkg::TONE_PERIOD_C3;
        set_table[0] = make_entry(watch_pkg::KEY_HOUR_DOWN, 1, 23, 0);  // Down from 0
        set_table[1] = make_entry(watch_pkg::KEY_HOUR_UP, 2, 1, 0);     // Past 23
        set_table[2] = make_entry(watch_pkg::KEY_MIN_DOWN, 1, 1, 59);
        set_table[3] = make_entry(watch_pkg::KEY_MIN_UP, 3, 1, 2);
        set_table[4] = make_entry(watch_pkg::KEY_HOUR_UP, 1, 2, 2);
        repeat (2) @(negedge clock);
        reset = 1'b1;

        check_time(0, 0, 0);
        check_led('0);
        repeat (2000) begin
            @(negedge clock);
            if (piezo !== 1'b0) report_mismatch("piezo active after reset");
        end

        for (int i = 0; i < 5; i++) begin
            entry = set_table[i];
            take_bits(2, extra);
            select_mode(entry.mode);
            press_times(entry.key, entry.count + extra);
            if (entry.key == watch_pkg::KEY_HOUR_DOWN)
                hour_off = (hour_off + 24 - extra) % 24;
            else if (entry.key == watch_pkg::KEY_HOUR_UP)
                hour_off = (hour_off + extra) % 24;
            else if (entry.key == watch_pkg::KEY_MIN_DOWN)
                minute_off = (minute_off + 60 - extra) % 60;
            else
                minute_off = (minute_off + extra) % 60;
            check_time((entry.hour + hour_off) % 24, (entry.minute + minute_off) % 60, 0);
        end

        set_field(watch_pkg::KEY_HOUR_DOWN, watch_pkg::KEY_HOUR_UP, hour, 23, 24);
        set_field(watch_pkg::KEY_MIN_DOWN, watch_pkg::KEY_MIN_UP, minute, 59, 60);
        set_field(watch_pkg::KEY_SEC_DOWN, watch_pkg::KEY_SEC_UP, second, 58, 60);
        check_time(23, 59, 58);
        select_mode(watch_pkg::MODE_RUN);
        wait_second_change(1_100_000);
        check_time(23, 59, 59);
        wait_second_change(1_100_000);
        check_time(0, 0, 0);

        take_bits(3, note_idx);
        recorded_half = tone_periods[note_idx] / 2 + 1;
        select_mode(watch_pkg::MODE_RECORD);
        button.tune.notes[note_idx] = 1'b1;
        measure_tone(recorded_half, 250 * watch_pkg::CLOCKS_PER_TICK);
        button = '0;
        repeat (3 * watch_pkg::CLOCKS_PER_TICK) @(negedge clock);
        check_led(8'b0000_0001);  // Two notes fill the first segment

        select_mode(watch_pkg::MODE_SET_ALARM);
        press_key(watch_pkg::KEY_MIN_UP);
        press_key(watch_pkg::KEY_ALARM_TOGGLE);
        select_mode(watch_pkg::MODE_RUN);
        repeat (watch_pkg::CLOCKS_PER_TICK) @(negedge clock);
        check_led(8'b0000_0001);
        select_mode(watch_pkg::MODE_SET_TIME);
        set_field(watch_pkg::KEY_HOUR_DOWN, watch_pkg::KEY_HOUR_UP, hour, 0, 24);
        set_field(watch_pkg::KEY_MIN_DOWN, watch_pkg::KEY_MIN_UP, minute, 0, 60);
        set_field(watch_pkg::KEY_SEC_DOWN, watch_pkg::KEY_SEC_UP, second, 59, 60);
        check_time(0, 0, 59);
        select_mode(watch_pkg::MODE_RUN);
        wait_minute_change(1_100_000);
        check_time(0, 1, 0);
        wait_first_edge(10_000);
        measure_tone(recorded_half, 190 * watch_pkg::CLOCKS_PER_TICK);  // Into the second note
        wait_quiet(30_000);

        select_mode(watch_pkg::MODE_RECORD);
        press_key(watch_pkg::KEY_CLEAR);
        check_led('0);

        $display("*** PASSED ***");
        $finish;
    end
endmodule

//--- design/watch_top.sv
`timescale 1ns/1ps

module watch_top (
    input  logic clock,
    input  logic reset,
    input  logic [watch_pkg::MODE_IN_W-1:0] mode,
    input  logic [watch_pkg::BUTTON_W-1:0] button,
    output logic [watch_pkg::HOUR_W-1:0] hour,
    output logic [watch_pkg::MIN_W-1:0] minute,
    output logic [watch_pkg::MIN_W-1:0] second,
    output logic [watch_pkg::LED_W-1:0] led,
    output logic piezo
);
    logic tick;
    logic [watch_pkg::MODE_W-1:0] active_mode;
    watch_pkg::button_word_u key_pulse;
    logic [watch_pkg::NOTE_W-1:0] note_level;
    logic alarm_start;
    logic alarm_enabled;
    logic [watch_pkg::NOTE_W-1:0] play_note;

    panel_input panel0 (
        .clock(clock),
        .reset(reset),
        .mode(mode),
        .button(button),
        .tick(tick),
        .active_mode(active_mode),
        .key_pulse(key_pulse),
        .note_level(note_level)
    );

    time_keeper keeper0 (
        .clock(clock),
        .reset(reset),
        .tick(tick),
        .active_mode(active_mode),
        .key_pulse(key_pulse),
        .hour(hour),
        .minute(minute),
        .second(second)
    );

    alarm_unit alarm0 (
        .clock(clock),
        .reset(reset),
        .active_mode(active_mode),
        .key_pulse(key_pulse),
        .hour(hour),
        .minute(minute),
        .second(second),
        .alarm_start(alarm_start),
        .alarm_enabled(alarm_enabled)
    );

    melody_recorder recorder0 (
        .clock(clock),
        .reset(reset),
        .tick(tick),
        .active_mode(active_mode),
        .key_pulse(key_pulse),
        .note_level(note_level),
        .alarm_start(alarm_start),
        .alarm_enabled(alarm_enabled),
        .play_note(play_note),
        .led(led)
    );

    tone_generator tone0 (
        .clock(clock),
        .reset(reset),
        .play_note(play_note),
        .piezo(piezo)
    );
endmodule

//--- design/tone_generator.sv
`timescale 1ns/1ps

module tone_generator (
    input  logic clock,
    input  logic reset,
    input  logic [watch_pkg::NOTE_W-1:0] play_note,
    output logic piezo
);
    logic [watch_pkg::TONE_W-1:0] period;
    logic [watch_pkg::TONE_W-1:0] count;

    always_comb begin
        casez (play_note)  // Highest key wins
            8'b1???????: period = watch_pkg::TONE_PERIOD_C3;
            8'b01??????: period = watch_pkg::TONE_PERIOD_B2;
            8'b001?????: period = watch_pkg::TONE_PERIOD_A2;
            8'b0001????: period = watch_pkg::TONE_PERIOD_G2;
            8'b00001???: period = watch_pkg::TONE_PERIOD_F2;
            8'b000001??: period = watch_pkg::TONE_PERIOD_E2;
            8'b0000001?: period = watch_pkg::TONE_PERIOD_D2;
            8'b00000001: period = watch_pkg::TONE_PERIOD_C2;
            default: period = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            piezo <= 1'b0;
            count <= '0;
        end else if (period == '0) begin
            piezo <= 1'b0;
            count <= '0;
        end else if (count >= (period >> 1)) begin
            piezo <= ~piezo;  // Half period plus one cycles per level
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end
endmodule

//--- design/melody_recorder.sv
`timescale 1ns/1ps

module melody_recorder (
    input  logic clock,
    input  logic reset,
    input  logic tick,
    input  logic [watch_pkg::MODE_W-1:0] active_mode,
    input  watch_pkg::button_word_u key_pulse,
    input  logic [watch_pkg::NOTE_W-1:0] note_level,
    input  logic alarm_start,
    input  logic alarm_enabled,
    output logic [watch_pkg::NOTE_W-1:0] play_note,
    output logic [watch_pkg::LED_W-1:0] led
);
    logic [watch_pkg::NOTE_W-1:0] melody [watch_pkg::MELODY_DEPTH];
    logic [watch_pkg::LEN_W-1:0] length;
    logic [watch_pkg::LEN_W-1:0] play_idx;
    logic [$clog2(watch_pkg::SAMPLE_TICKS)-1:0] sample_count;
    logic playing;
    logic record_mode;
    logic sample_done;
    logic clear_req;
    logic start_req;
    logic recording;
    logic store;
    logic [watch_pkg::LED_W-1:0] level_bar;

    assign record_mode = (active_mode == watch_pkg::MODE_RECORD);
    assign sample_done = (sample_count == watch_pkg::SAMPLE_TICKS - 1);
    assign clear_req = record_mode && key_pulse.keys[watch_pkg::KEY_CLEAR];
    assign start_req = (alarm_start || (record_mode && key_pulse.keys[watch_pkg::KEY_PLAY])) &&
                       !playing && (length != '0);
    assign recording = record_mode && !playing && (|note_level) &&
                       (length < watch_pkg::MELODY_DEPTH);
    assign store = tick && recording && sample_done && !clear_req && !start_req;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            length <= '0;
            play_idx <= '0;
            sample_count <= '0;
            playing <= 1'b0;
        end else if (clear_req) begin
            length <= '0;  // Old slots get overwritten by the next recording
            play_idx <= '0;
            sample_count <= '0;
            playing <= 1'b0;
        end else if (start_req) begin
            play_idx <= '0;
            sample_count <= '0;
            playing <= 1'b1;
        end else if (tick) begin
            if (playing) begin
                if (sample_done) begin
                    sample_count <= '0;
                    if (play_idx == length - 1'b1) begin
                        playing <= 1'b0;
                        play_idx <= '0;
                    end else begin
                        play_idx <= play_idx + 1'b1;
                    end
                end else begin
                    sample_count <= sample_count + 1'b1;
                end
            end else if (recording) begin
                if (sample_done) begin
                    sample_count <= '0;
                    length <= length + 1'b1;
                end else begin
                    sample_count <= sample_count + 1'b1;
                end
            end else begin
                sample_count <= '0;  // Key released, restart the note window
            end
        end
    end

    always_ff @(posedge clock) begin
        if (store) begin
            melody[length] <= note_level;
        end
    end

    always_comb begin
        for (int i = 0; i < watch_pkg::LED_W; i++) begin
            level_bar[i] = (length != '0) && (length >= i * watch_pkg::LED_STEP);
        end
        if (playing) play_note = melody[play_idx];
        else if (record_mode) play_note = note_level;
        else play_note = '0;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) led <= '0;
        else if (record_mode) led <= level_bar;
        else led <= {{(watch_pkg::LED_W-1){1'b0}}, alarm_enabled};
    end
endmodule

//--- design/alarm_unit.sv
`timescale 1ns/1ps

module alarm_unit (
    input  logic clock,
    input  logic reset,
    input  logic [watch_pkg::MODE_W-1:0] active_mode,
    input  watch_pkg::button_word_u key_pulse,
    input  logic [watch_pkg::HOUR_W-1:0] hour,
    input  logic [watch_pkg::MIN_W-1:0] minute,
    input  logic [watch_pkg::MIN_W-1:0] second,
    output logic alarm_start,
    output logic alarm_enabled
);
    logic [watch_pkg::HOUR_W-1:0] alarm_hour;
    logic [watch_pkg::MIN_W-1:0] alarm_minute;
    logic triggered;
    logic set_mode;

    assign set_mode = (active_mode == watch_pkg::MODE_SET_ALARM);
    assign alarm_start = (active_mode != watch_pkg::MODE_RECORD) && alarm_enabled && !triggered &&
                         (hour == alarm_hour) && (minute == alarm_minute) && (second == '0);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            alarm_hour <= '0;
            alarm_minute <= '0;
            alarm_enabled <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (alarm_start) begin
                triggered <= 1'b1;
            end else if (second != '0) begin
                triggered <= 1'b0;  // Rearm once the matching second has passed
            end
            if (set_mode && key_pulse.keys[watch_pkg::KEY_HOUR_DOWN]) begin
                alarm_hour <= (alarm_hour == '0) ? watch_pkg::HOURS_PER_DAY - 1'b1 : alarm_hour - 1'b1;
            end else if (set_mode && key_pulse.keys[watch_pkg::KEY_HOUR_UP]) begin
                alarm_hour <= (alarm_hour == watch_pkg::HOURS_PER_DAY - 1'b1) ? '0 : alarm_hour + 1'b1;
            end
            if (set_mode && key_pulse.keys[watch_pkg::KEY_MIN_DOWN]) begin
                alarm_minute <= (alarm_minute == '0) ? watch_pkg::MINUTES_PER_HOUR - 1'b1 :
                                alarm_minute - 1'b1;
            end else if (set_mode && key_pulse.keys[watch_pkg::KEY_MIN_UP]) begin
                alarm_minute <= (alarm_minute == watch_pkg::MINUTES_PER_HOUR - 1'b1) ? '0 :
                                alarm_minute + 1'b1;
            end
            if (set_mode && key_pulse.keys[watch_pkg::KEY_ALARM_TOGGLE]) begin
                alarm_enabled <= !alarm_enabled;
            end
        end
    end
endmodule

//--- design/time_keeper.sv
`timescale 1ns/1ps

module time_keeper (
    input  logic clock,
    input  logic reset,
    input  logic tick,
    input  logic [watch_pkg::MODE_W-1:0] active_mode,
    input  watch_pkg::button_word_u key_pulse,
    output logic [watch_pkg::HOUR_W-1:0] hour,
    output logic [watch_pkg::MIN_W-1:0] minute,
    output logic [watch_pkg::MIN_W-1:0] second
);
    logic [$clog2(watch_pkg::TICKS_PER_SECOND)-1:0] ms_count;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ms_count <= '0;
            hour <= '0;
            minute <= '0;
            second <= '0;
        end else if (active_mode == watch_pkg::MODE_RUN) begin
            if (tick) begin
                if (ms_count == watch_pkg::TICKS_PER_SECOND - 1) begin
                    ms_count <= '0;
                    if (second == watch_pkg::MINUTES_PER_HOUR - 1'b1) begin
                        second <= '0;
                        if (minute == watch_pkg::MINUTES_PER_HOUR - 1'b1) begin
                            minute <= '0;
                            hour <= (hour == watch_pkg::HOURS_PER_DAY - 1'b1) ? '0 : hour + 1'b1;
                        end else begin
                            minute <= minute + 1'b1;
                        end
                    end else begin
                        second <= second + 1'b1;
                    end
                end else begin
                    ms_count <= ms_count + 1'b1;
                end
            end
        end else if (active_mode == watch_pkg::MODE_SET_TIME) begin
            // Down wins if both keys of a field arrive together
            if (key_pulse.keys[watch_pkg::KEY_HOUR_DOWN]) begin
                hour <= (hour == '0) ? watch_pkg::HOURS_PER_DAY - 1'b1 : hour - 1'b1;
            end else if (key_pulse.keys[watch_pkg::KEY_HOUR_UP]) begin
                hour <= (hour == watch_pkg::HOURS_PER_DAY - 1'b1) ? '0 : hour + 1'b1;
            end
            if (key_pulse.keys[watch_pkg::KEY_MIN_DOWN]) begin
                minute <= (minute == '0) ? watch_pkg::MINUTES_PER_HOUR - 1'b1 : minute - 1'b1;
            end else if (key_pulse.keys[watch_pkg::KEY_MIN_UP]) begin
                minute <= (minute == watch_pkg::MINUTES_PER_HOUR - 1'b1) ? '0 : minute + 1'b1;
            end
            if (key_pulse.keys[watch_pkg::KEY_SEC_DOWN]) begin
                second <= (second == '0) ? watch_pkg::MINUTES_PER_HOUR - 1'b1 : second - 1'b1;
            end else if (key_pulse.keys[watch_pkg::KEY_SEC_UP]) begin
                second <= (second == watch_pkg::MINUTES_PER_HOUR - 1'b1) ? '0 : second + 1'b1;
            end
        end
    end
endmodule

//--- design/panel_input.sv
`timescale 1ns/1ps

module panel_input (
    input  logic clock,
    input  logic reset,
    input  logic [watch_pkg::MODE_IN_W-1:0] mode,
    input  logic [watch_pkg::BUTTON_W-1:0] button,
    output logic tick,
    output logic [watch_pkg::MODE_W-1:0] active_mode,
    output watch_pkg::button_word_u key_pulse,
    output logic [watch_pkg::NOTE_W-1:0] note_level
);
    logic [$clog2(watch_pkg::CLOCKS_PER_TICK)-1:0] div_count;
    watch_pkg::button_word_u btn_sync;
    logic [watch_pkg::BUTTON_W-1:0] btn_prev;

    assign tick = (div_count == watch_pkg::CLOCKS_PER_TICK - 1);
    assign note_level = btn_sync.tune.notes;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            div_count <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
        end else if (tick) begin
            div_count <= '0;
            btn_sync.keys <= button;
            btn_prev <= btn_sync.keys;  // Level seen one tick earlier
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    always_comb begin
        key_pulse.keys = tick ? (btn_sync.keys & ~btn_prev) : '0;
        if (mode[3]) active_mode = watch_pkg::MODE_SET_TIME;
        else if (mode[2]) active_mode = watch_pkg::MODE_SET_ALARM;
        else if (mode[1]) active_mode = watch_pkg::MODE_RECORD;
        else active_mode = watch_pkg::MODE_RUN;
    end
endmodule

//--- design/watch_pkg.sv
package watch_pkg;

    localparam int CLOCKS_PER_TICK = 1000;  // 1 MHz clock to 1 ms tick
    localparam int TICKS_PER_SECOND = 1000;
    localparam int SAMPLE_TICKS = 100;      // 100 ms per note
    localparam int MELODY_DEPTH = 80;
    localparam int LED_STEP = 10;

    localparam int HOUR_W = 5;
    localparam int MIN_W = 6;
    localparam int NOTE_W = 8;
    localparam int LEN_W = 7;
    localparam int MODE_W = 2;
    localparam int MODE_IN_W = 4;
    localparam int BUTTON_W = 12;
    localparam int LED_W = 8;
    localparam int TONE_W = 12;

    localparam logic [HOUR_W-1:0] HOURS_PER_DAY = 5'd24;
    localparam logic [MIN_W-1:0] MINUTES_PER_HOUR = 6'd60;

    localparam logic [MODE_W-1:0] MODE_RUN = 2'd0;
    localparam logic [MODE_W-1:0] MODE_SET_TIME = 2'd1;
    localparam logic [MODE_W-1:0] MODE_SET_ALARM = 2'd2;
    localparam logic [MODE_W-1:0] MODE_RECORD = 2'd3;

    // Full periods in clock cycles
    localparam logic [TONE_W-1:0] TONE_PERIOD_C2 = 12'd3830;
    localparam logic [TONE_W-1:0] TONE_PERIOD_D2 = 12'd3400;
    localparam logic [TONE_W-1:0] TONE_PERIOD_E2 = 12'd3038;
    localparam logic [TONE_W-1:0] TONE_PERIOD_F2 = 12'd2864;
    localparam logic [TONE_W-1:0] TONE_PERIOD_G2 = 12'd2550;
    localparam logic [TONE_W-1:0] TONE_PERIOD_A2 = 12'd2272;
    localparam logic [TONE_W-1:0] TONE_PERIOD_B2 = 12'd2028;
    localparam logic [TONE_W-1:0] TONE_PERIOD_C3 = 12'd1912;

    // Set keys share bits with record keys, meaning depends on mode
    localparam int KEY_HOUR_DOWN = 11;
    localparam int KEY_HOUR_UP = 9;
    localparam int KEY_MIN_DOWN = 8;
    localparam int KEY_MIN_UP = 6;
    localparam int KEY_SEC_DOWN = 5;
    localparam int KEY_SEC_UP = 3;
    localparam int KEY_ALARM_TOGGLE = 0;
    localparam int KEY_PLAY = 11;
    localparam int KEY_CLEAR = 10;

    typedef union packed {
        logic [BUTTON_W-1:0] keys;
        struct packed {
            logic [BUTTON_W-NOTE_W-1:0] ctrl;
            logic [NOTE_W-1:0] notes;
        } tune;
    } button_word_u;

endpackage
